/* source/bp_pkg.sv */
// Sizes and enums shared by every block of the branch target buffer
// Set index is a 5-bit XOR hash of the word address, common to all ways
// Tag width assumes full 32-bit PCs with no virtual address trimming

package bp_pkg;

    ////////////////////////////////////////////////////////////
    // Geometry

    localparam int ADDR_W = 32;
    localparam int WAYS   = 2;
    localparam int SET_W  = 5;
    localparam int SETS   = 2 ** SET_W;

    // Upper PC bits above the index and the byte offset
    localparam int TAG_W = ADDR_W - SET_W - 2;

    // Fetch identifiers in flight
    localparam int ID_W    = 3;
    localparam int MAX_IDS = 8;

    ////////////////////////////////////////////////////////////
    // Encodings

    // 2-bit saturating counter, top bit is the predicted direction
    typedef enum logic [1:0] {
        ctr_strong_nt = 2'b00,
        ctr_weak_nt   = 2'b01,
        ctr_weak_t    = 2'b10,
        ctr_strong_t  = 2'b11
    } ctr_t;

    // Update channel sequencer
    typedef enum logic [1:0] {
        upd_idle  = 2'b00,
        upd_read  = 2'b01,
        upd_write = 2'b10,
        upd_ack   = 2'b11
    } upd_state_t;

endpackage

/* source/bp_index_hash.sv */
// Set index is word address bits XOR the next SET_W bits, same for every way
// Lookup tag, id and valid are delayed one cycle to meet the RAM read data
// Update side is combinational, upd_pc must be stable while upd_req is high

`timescale 1ns/10ps

module bp_index_hash (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      lookup_valid,
    input  logic [bp_pkg::ADDR_W-1:0] lookup_pc,
    input  logic [bp_pkg::ID_W-1:0]   lookup_id,
    input  logic [bp_pkg::ADDR_W-1:0] upd_pc,
    output logic [bp_pkg::SET_W-1:0]  rd_set,
    output logic [bp_pkg::TAG_W-1:0]  lookup_tag_q,
    output logic [bp_pkg::ID_W-1:0]   lookup_id_q,
    output logic                      lookup_valid_q,
    output logic [bp_pkg::SET_W-1:0]  wr_set,
    output logic [bp_pkg::TAG_W-1:0]  wr_tag
);

    // Fold the two lowest SET_W-wide groups of the word address
    function automatic logic [bp_pkg::SET_W-1:0] set_hash(
        input logic [bp_pkg::ADDR_W-1:0] pc
    );
        return pc[bp_pkg::SET_W+1:2] ^ pc[2*bp_pkg::SET_W+1:bp_pkg::SET_W+2];
    endfunction

    function automatic logic [bp_pkg::TAG_W-1:0] pc_tag(
        input logic [bp_pkg::ADDR_W-1:0] pc
    );
        return pc[bp_pkg::ADDR_W-1:bp_pkg::SET_W+2];
    endfunction

    assign rd_set = set_hash(lookup_pc);
    assign wr_set = set_hash(upd_pc);
    assign wr_tag = pc_tag(upd_pc);

    // Lookup stage register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lookup_valid_q <= 1'b0;
        end else begin
            lookup_valid_q <= lookup_valid;
        end
    end

    always_ff @(posedge clk) begin
        lookup_tag_q <= pc_tag(lookup_pc);
        lookup_id_q  <= lookup_id;
    end

endmodule

/* source/bp_way_bank.sv */
// One way of the BTB, one entry per set, synchronous read every cycle
// A write and a read of the same set in one cycle return the old entry
// Target store is written only with write_en and target_write_en together

`timescale 1ns/10ps

module bp_way_bank (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [bp_pkg::SET_W-1:0]  rd_set,
    input  logic [bp_pkg::TAG_W-1:0]  lookup_tag_q,
    input  logic [bp_pkg::SET_W-1:0]  wr_set,
    input  logic [bp_pkg::TAG_W-1:0]  wr_tag,
    input  logic                      write_en,
    input  logic                      target_write_en,
    input  bp_pkg::ctr_t              wr_ctr,
    input  logic [bp_pkg::ADDR_W-1:0] wr_target,
    input  logic                      wr_is_branch,
    input  logic                      wr_is_call,
    input  logic                      wr_is_return,
    output logic                      way_hit,
    output logic [bp_pkg::ADDR_W-1:0] way_target,
    output bp_pkg::ctr_t              way_ctr,
    output logic                      way_is_branch,
    output logic                      way_is_call,
    output logic                      way_is_return
);

    logic [bp_pkg::SETS-1:0] valid_q;
    logic                    rd_valid_q;

    // Entry layout is tag, branch, call, return, counter
    logic [bp_pkg::TAG_W+4:0]  meta_mem [bp_pkg::SETS];
    logic [bp_pkg::TAG_W+4:0]  meta_q;
    logic [bp_pkg::ADDR_W-1:0] target_mem [bp_pkg::SETS];
    logic [bp_pkg::ADDR_W-1:0] target_q;

    ////////////////////////////////////////////////////////////
    // Valid bits

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= valid_q[rd_set];
            if (write_en) begin
                valid_q[wr_set] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Entry stores

    always_ff @(posedge clk) begin
        if (write_en) begin
            meta_mem[wr_set] <= {wr_tag, wr_is_branch, wr_is_call, wr_is_return, wr_ctr};
        end
        meta_q <= meta_mem[rd_set];
    end

    always_ff @(posedge clk) begin
        if (write_en && target_write_en) begin
            target_mem[wr_set] <= wr_target;
        end
        target_q <= target_mem[rd_set];
    end

    // Compare against the tag that was registered with the read
    assign way_hit       = rd_valid_q && (meta_q[bp_pkg::TAG_W+4:5] == lookup_tag_q);
    assign way_target    = target_q;
    assign way_is_branch = meta_q[4];
    assign way_is_call   = meta_q[3];
    assign way_is_return = meta_q[2];
    assign way_ctr       = bp_pkg::ctr_t'(meta_q[1:0]);

endmodule

/* source/bp_hit_select.sv */
// Merges the way outputs, expects at most one way_hit bit set
// All prediction fields read zero on a miss or when no lookup is pending

`timescale 1ns/10ps

module bp_hit_select (
    input  logic                                      lookup_valid_q,
    input  logic [bp_pkg::WAYS-1:0]                   way_hit,
    input  logic [bp_pkg::WAYS-1:0][bp_pkg::ADDR_W-1:0] way_target,
    input  bp_pkg::ctr_t [bp_pkg::WAYS-1:0]           way_ctr,
    input  logic [bp_pkg::WAYS-1:0]                   way_is_branch,
    input  logic [bp_pkg::WAYS-1:0]                   way_is_call,
    input  logic [bp_pkg::WAYS-1:0]                   way_is_return,
    output logic                                      pred_valid,
    output logic                                      pred_hit,
    output logic [bp_pkg::ADDR_W-1:0]                 pred_target,
    output logic                                      pred_taken,
    output logic                                      pred_is_branch,
    output logic                                      pred_is_call,
    output logic                                      pred_is_return,
    output logic [bp_pkg::WAYS-1:0]                   hit_way,
    output bp_pkg::ctr_t                              hit_ctr
);

    logic [1:0] ctr_bits;

    // Only a pending lookup can hit
    assign hit_way    = way_hit & {bp_pkg::WAYS{lookup_valid_q}};
    assign pred_valid = lookup_valid_q;
    assign pred_hit   = |hit_way;

    // One-hot AND-OR mux
    always_comb begin
        pred_target    = '0;
        ctr_bits       = '0;
        pred_is_branch = 1'b0;
        pred_is_call   = 1'b0;
        pred_is_return = 1'b0;
        for (int w = 0; w < bp_pkg::WAYS; w++) begin
            if (hit_way[w]) begin
                pred_target    = pred_target | way_target[w];
                ctr_bits       = ctr_bits | way_ctr[w];
                pred_is_branch = pred_is_branch | way_is_branch[w];
                pred_is_call   = pred_is_call | way_is_call[w];
                pred_is_return = pred_is_return | way_is_return[w];
            end
        end
    end

    assign hit_ctr    = bp_pkg::ctr_t'(ctr_bits);
    assign pred_taken = ctr_bits[1];

endmodule

/* source/bp_update_ctrl.sv */
// Records each lookup outcome by fetch id, replays it on the update channel
// Four-phase req/ack, upd_ack rises 3 cycles after upd_req is seen in idle
// Victim pointer only moves when an update allocates a new entry

`timescale 1ns/10ps

module bp_update_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    lookup_valid_q,
    input  logic [bp_pkg::ID_W-1:0] lookup_id_q,
    input  logic                    pred_hit,
    input  logic [bp_pkg::WAYS-1:0] hit_way,
    input  bp_pkg::ctr_t            hit_ctr,
    input  logic                    upd_req,
    input  logic [bp_pkg::ID_W-1:0] upd_id,
    input  logic                    upd_taken,
    input  logic                    upd_is_branch,
    output logic                    upd_ack,
    output logic                    retired,
    output logic [bp_pkg::WAYS-1:0] way_write_en,
    output logic                    target_write_en,
    output bp_pkg::ctr_t            wr_ctr
);

    bp_pkg::upd_state_t state_q;
    bp_pkg::upd_state_t state_d;

    // Per-id lookup record
    logic                    meta_hit_mem [bp_pkg::MAX_IDS];
    logic [bp_pkg::WAYS-1:0] meta_way_mem [bp_pkg::MAX_IDS];
    bp_pkg::ctr_t            meta_ctr_mem [bp_pkg::MAX_IDS];

    logic                    meta_hit_q;
    logic [bp_pkg::WAYS-1:0] meta_way_q;
    bp_pkg::ctr_t            meta_ctr_q;

    logic [bp_pkg::WAYS-1:0] victim_q;
    logic [bp_pkg::WAYS-1:0] sel_way;
    logic                    in_write;

    ////////////////////////////////////////////////////////////
    // Metadata table

    always_ff @(posedge clk) begin
        if (lookup_valid_q) begin
            meta_hit_mem[lookup_id_q] <= pred_hit;
            meta_way_mem[lookup_id_q] <= hit_way;
            meta_ctr_mem[lookup_id_q] <= hit_ctr;
        end
        if (state_q == bp_pkg::upd_read) begin
            meta_hit_q <= meta_hit_mem[upd_id];
            meta_way_q <= meta_way_mem[upd_id];
            meta_ctr_q <= meta_ctr_mem[upd_id];
        end
    end

    ////////////////////////////////////////////////////////////
    // Update sequencer

    always_comb begin
        state_d = state_q;
        case (state_q)
            bp_pkg::upd_idle:  if (upd_req) state_d = bp_pkg::upd_read;
            bp_pkg::upd_read:  state_d = bp_pkg::upd_write;
            bp_pkg::upd_write: state_d = bp_pkg::upd_ack;
            // Hold ack until the requester lets go
            bp_pkg::upd_ack:   if (!upd_req) state_d = bp_pkg::upd_idle;
            default:           state_d = bp_pkg::upd_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= bp_pkg::upd_idle;
            victim_q    <= '0;
            victim_q[0] <= 1'b1;
        end else begin
            state_q <= state_d;
            // Rotate on allocation only
            if (in_write && !meta_hit_q) begin
                victim_q <= {victim_q[bp_pkg::WAYS-2:0], victim_q[bp_pkg::WAYS-1]};
            end
        end
    end

    assign in_write = (state_q == bp_pkg::upd_write);
    assign upd_ack  = (state_q == bp_pkg::upd_ack);

    ////////////////////////////////////////////////////////////
    // Counter and write enables

    always_comb begin
        if (!meta_hit_q) begin
            wr_ctr = upd_taken ? bp_pkg::ctr_strong_t : bp_pkg::ctr_strong_nt;
        end else begin
            case (meta_ctr_q)
                bp_pkg::ctr_strong_nt: wr_ctr = upd_taken ? bp_pkg::ctr_weak_nt : bp_pkg::ctr_strong_nt;
                bp_pkg::ctr_weak_nt:   wr_ctr = upd_taken ? bp_pkg::ctr_weak_t : bp_pkg::ctr_strong_nt;
                bp_pkg::ctr_weak_t:    wr_ctr = upd_taken ? bp_pkg::ctr_strong_t : bp_pkg::ctr_weak_nt;
                default:               wr_ctr = upd_taken ? bp_pkg::ctr_strong_t : bp_pkg::ctr_weak_t;
            endcase
        end
    end

    // Recorded hit way wins, else the current victim
    assign sel_way      = meta_hit_q ? meta_way_q : victim_q;
    assign way_write_en = sel_way & {bp_pkg::WAYS{in_write}};

    // Keep the old target unless the direction flipped
    assign target_write_en = in_write && (!meta_hit_q || (meta_ctr_q[1] ^ wr_ctr[1]));
    assign retired         = in_write && meta_hit_q && upd_is_branch;

endmodule

/* source/branch_predictor.sv */
// Set-associative BTB, lookup result one cycle after lookup_valid
// Lookups never stall, updates use a four-phase req/ack channel
// The return-address stack sits outside and listens to retired

`timescale 1ns/10ps

module branch_predictor (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      lookup_valid,
    input  logic [bp_pkg::ADDR_W-1:0] lookup_pc,
    input  logic [bp_pkg::ID_W-1:0]   lookup_id,
    input  logic                      upd_req,
    input  logic [bp_pkg::ID_W-1:0]   upd_id,
    input  logic [bp_pkg::ADDR_W-1:0] upd_pc,
    input  logic [bp_pkg::ADDR_W-1:0] upd_target,
    input  logic                      upd_taken,
    input  logic                      upd_is_branch,
    input  logic                      upd_is_call,
    input  logic                      upd_is_return,
    output logic                      pred_valid,
    output logic                      pred_hit,
    output logic [bp_pkg::ADDR_W-1:0] pred_target,
    output logic                      pred_taken,
    output logic                      pred_is_branch,
    output logic                      pred_is_call,
    output logic                      pred_is_return,
    output logic                      upd_ack,
    output logic                      retired
);

    logic [bp_pkg::SET_W-1:0] rd_set;
    logic [bp_pkg::SET_W-1:0] wr_set;
    logic [bp_pkg::TAG_W-1:0] lookup_tag_q;
    logic [bp_pkg::TAG_W-1:0] wr_tag;
    logic [bp_pkg::ID_W-1:0]  lookup_id_q;
    logic                     lookup_valid_q;

    // Per-way read side
    logic [bp_pkg::WAYS-1:0]                     way_hit;
    logic [bp_pkg::WAYS-1:0][bp_pkg::ADDR_W-1:0] way_target;
    bp_pkg::ctr_t [bp_pkg::WAYS-1:0]             way_ctr;
    logic [bp_pkg::WAYS-1:0]                     way_is_branch;
    logic [bp_pkg::WAYS-1:0]                     way_is_call;
    logic [bp_pkg::WAYS-1:0]                     way_is_return;

    logic [bp_pkg::WAYS-1:0] hit_way;
    bp_pkg::ctr_t            hit_ctr;
    logic [bp_pkg::WAYS-1:0] way_write_en;
    logic                    target_write_en;
    bp_pkg::ctr_t            wr_ctr;

    bp_index_hash u_hash (
        .clk            (clk),
        .rst_n          (rst_n),
        .lookup_valid   (lookup_valid),
        .lookup_pc      (lookup_pc),
        .lookup_id      (lookup_id),
        .upd_pc         (upd_pc),
        .rd_set         (rd_set),
        .lookup_tag_q   (lookup_tag_q),
        .lookup_id_q    (lookup_id_q),
        .lookup_valid_q (lookup_valid_q),
        .wr_set         (wr_set),
        .wr_tag         (wr_tag)
    );

    for (genvar g = 0; g < bp_pkg::WAYS; g++) begin : gen_way
        bp_way_bank u_way (
            .clk             (clk),
            .rst_n           (rst_n),
            .rd_set          (rd_set),
            .lookup_tag_q    (lookup_tag_q),
            .wr_set          (wr_set),
            .wr_tag          (wr_tag),
            .write_en        (way_write_en[g]),
            .target_write_en (target_write_en),
            .wr_ctr          (wr_ctr),
            .wr_target       (upd_target),
            .wr_is_branch    (upd_is_branch),
            .wr_is_call      (upd_is_call),
            .wr_is_return    (upd_is_return),
            .way_hit         (way_hit[g]),
            .way_target      (way_target[g]),
            .way_ctr         (way_ctr[g]),
            .way_is_branch   (way_is_branch[g]),
            .way_is_call     (way_is_call[g]),
            .way_is_return   (way_is_return[g])
        );
    end

    bp_hit_select u_select (
        .lookup_valid_q (lookup_valid_q),
        .way_hit        (way_hit),
        .way_target     (way_target),
        .way_ctr        (way_ctr),
        .way_is_branch  (way_is_branch),
        .way_is_call    (way_is_call),
        .way_is_return  (way_is_return),
        .pred_valid     (pred_valid),
        .pred_hit       (pred_hit),
        .pred_target    (pred_target),
        .pred_taken     (pred_taken),
        .pred_is_branch (pred_is_branch),
        .pred_is_call   (pred_is_call),
        .pred_is_return (pred_is_return),
        .hit_way        (hit_way),
        .hit_ctr        (hit_ctr)
    );

    bp_update_ctrl u_update (
        .clk             (clk),
        .rst_n           (rst_n),
        .lookup_valid_q  (lookup_valid_q),
        .lookup_id_q     (lookup_id_q),
        .pred_hit        (pred_hit),
        .hit_way         (hit_way),
        .hit_ctr         (hit_ctr),
        .upd_req         (upd_req),
        .upd_id          (upd_id),
        .upd_taken       (upd_taken),
        .upd_is_branch   (upd_is_branch),
        .upd_ack         (upd_ack),
        .retired         (retired),
        .way_write_en    (way_write_en),
        .target_write_en (target_write_en),
        .wr_ctr          (wr_ctr)
    );

endmodule

/* verif/tb_branch_predictor.sv */
// Self-checking testbench with a reference model of every set and way of the BTB
// Inputs change and outputs are sampled 0.5 ns after each rising edge
// Random lookup/update pairs use a fixed seed over a small PC pool

`timescale 1ns/10ps

module tb_branch_predictor;

    localparam int TIMEOUT = 20;
    localparam int POOL    = 8;

    // Prediction as seen on the fetch side
    typedef struct packed {
        logic                      hit;
        logic [bp_pkg::ADDR_W-1:0] target;
        logic                      taken;
        logic                      is_branch;
        logic                      is_call;
        logic                      is_return;
    } pred_t;

    logic                      clk;
    logic                      rst_n;
    logic                      lookup_valid;
    logic [bp_pkg::ADDR_W-1:0] lookup_pc;
    logic [bp_pkg::ID_W-1:0]   lookup_id;
    logic                      upd_req;
    logic [bp_pkg::ID_W-1:0]   upd_id;
    logic [bp_pkg::ADDR_W-1:0] upd_pc;
    logic [bp_pkg::ADDR_W-1:0] upd_target;
    logic                      upd_taken;
    logic                      upd_is_branch;
    logic                      upd_is_call;
    logic                      upd_is_return;
    logic                      pred_valid;
    logic                      pred_hit;
    logic [bp_pkg::ADDR_W-1:0] pred_target;
    logic                      pred_taken;
    logic                      pred_is_branch;
    logic                      pred_is_call;
    logic                      pred_is_return;
    logic                      upd_ack;
    logic                      retired;

    // Reference state per way and set
    // Kind bits are {branch, call, return}
    logic                      ref_valid  [bp_pkg::WAYS][bp_pkg::SETS];
    logic [bp_pkg::TAG_W-1:0]  ref_tag    [bp_pkg::WAYS][bp_pkg::SETS];
    logic [bp_pkg::ADDR_W-1:0] ref_target [bp_pkg::WAYS][bp_pkg::SETS];
    logic [1:0]                ref_ctr    [bp_pkg::WAYS][bp_pkg::SETS];
    logic [2:0]                ref_kind   [bp_pkg::WAYS][bp_pkg::SETS];
    int                        ref_victim;

    // Lookup record per fetch id
    logic                      rec_hit [bp_pkg::MAX_IDS];
    int                        rec_way [bp_pkg::MAX_IDS];
    logic [1:0]                rec_ctr [bp_pkg::MAX_IDS];

    logic [bp_pkg::ADDR_W-1:0] pool [POOL];
    integer                    seed;

    branch_predictor u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .lookup_valid   (lookup_valid),
        .lookup_pc      (lookup_pc),
        .lookup_id      (lookup_id),
        .upd_req        (upd_req),
        .upd_id         (upd_id),
        .upd_pc         (upd_pc),
        .upd_target     (upd_target),
        .upd_taken      (upd_taken),
        .upd_is_branch  (upd_is_branch),
        .upd_is_call    (upd_is_call),
        .upd_is_return  (upd_is_return),
        .pred_valid     (pred_valid),
        .pred_hit       (pred_hit),
        .pred_target    (pred_target),
        .pred_taken     (pred_taken),
        .pred_is_branch (pred_is_branch),
        .pred_is_call   (pred_is_call),
        .pred_is_return (pred_is_return),
        .upd_ack        (upd_ack),
        .retired        (retired)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Error handling

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model

    // Word address XOR the next group of index bits
    function automatic int set_of(input logic [bp_pkg::ADDR_W-1:0] pc);
        logic [bp_pkg::ADDR_W-1:0] mix;
        mix = (pc >> 2) ^ (pc >> (2 + bp_pkg::SET_W));
        return int'(mix % bp_pkg::SETS);
    endfunction

    function automatic logic [bp_pkg::TAG_W-1:0] tag_of(input logic [bp_pkg::ADDR_W-1:0] pc);
        return pc >> (bp_pkg::SET_W + 2);
    endfunction

    function automatic pred_t ref_lookup(input logic [bp_pkg::ADDR_W-1:0] pc,
                                         input logic [bp_pkg::ID_W-1:0] id);
        pred_t res;
        int    set;
        set         = set_of(pc);
        res         = '0;
        rec_hit[id] = 1'b0;
        rec_way[id] = 0;
        rec_ctr[id] = 2'b00;
        for (int w = 0; w < bp_pkg::WAYS; w++) begin
            if (!res.hit && ref_valid[w][set] && ref_tag[w][set] == tag_of(pc)) begin
                res.hit       = 1'b1;
                res.target    = ref_target[w][set];
                res.taken     = ref_ctr[w][set][1];
                res.is_branch = ref_kind[w][set][2];
                res.is_call   = ref_kind[w][set][1];
                res.is_return = ref_kind[w][set][0];
                rec_hit[id]   = 1'b1;
                rec_way[id]   = w;
                rec_ctr[id]   = ref_ctr[w][set];
            end
        end
        return res;
    endfunction

    task automatic ref_update(input logic [bp_pkg::ID_W-1:0] id,
                              input logic [bp_pkg::ADDR_W-1:0] pc,
                              input logic [bp_pkg::ADDR_W-1:0] target,
                              input logic taken, input logic [2:0] kind,
                              output logic exp_retired);
        int         set;
        int         way;
        logic [1:0] new_ctr;
        set = set_of(pc);
        if (rec_hit[id]) begin
            way = rec_way[id];
            if (taken) begin
                new_ctr = (rec_ctr[id] == 2'b11) ? 2'b11 : rec_ctr[id] + 2'b01;
            end else begin
                new_ctr = (rec_ctr[id] == 2'b00) ? 2'b00 : rec_ctr[id] - 2'b01;
            end
        end else begin
            // Allocation takes the victim and moves the pointer on
            way        = ref_victim;
            ref_victim = (ref_victim + 1) % bp_pkg::WAYS;
            new_ctr    = taken ? 2'b11 : 2'b00;
        end
        if (!rec_hit[id] || (rec_ctr[id][1] != new_ctr[1])) begin
            ref_target[way][set] = target;
        end
        ref_valid[way][set] = 1'b1;
        ref_tag[way][set]   = tag_of(pc);
        ref_ctr[way][set]   = new_ctr;
        ref_kind[way][set]  = kind;
        exp_retired         = rec_hit[id] && kind[2];
    endtask

    ////////////////////////////////////////////////////////////
    // Bus tasks enter and leave 0.5 ns after a rising edge

    task automatic do_lookup(input logic [bp_pkg::ADDR_W-1:0] pc,
                             input logic [bp_pkg::ID_W-1:0] id, output pred_t got);
        int n;
        lookup_valid = 1'b1;
        lookup_pc    = pc;
        lookup_id    = id;
        for (n = 1; n <= TIMEOUT; n++) begin
            @(posedge clk);
            #0.5;
            lookup_valid = 1'b0;
            if (pred_valid) break;
        end
        if (n > TIMEOUT) stop_run("pred_valid never rose after a lookup");
        check_value("lookup_latency", n, 1);
        got = {pred_hit, pred_target, pred_taken, pred_is_branch, pred_is_call, pred_is_return};
    endtask

    task automatic do_update(input logic [bp_pkg::ID_W-1:0] id,
                             input logic [bp_pkg::ADDR_W-1:0] pc,
                             input logic [bp_pkg::ADDR_W-1:0] target,
                             input logic taken, input logic [2:0] kind,
                             input int hold, output int pulses);
        int n;
        pulses        = 0;
        upd_req       = 1'b1;
        upd_id        = id;
        upd_pc        = pc;
        upd_target    = target;
        upd_taken     = taken;
        upd_is_branch = kind[2];
        upd_is_call   = kind[1];
        upd_is_return = kind[0];
        for (n = 1; n <= TIMEOUT; n++) begin
            @(posedge clk);
            #0.5;
            if (retired) pulses++;
            if (upd_ack) break;
        end
        if (n > TIMEOUT) stop_run("upd_ack never rose while upd_req was high");
        check_value("upd_ack_latency", n, 3);
        // Slow requester holds upd_req while ack stays high
        for (int h = 0; h < hold; h++) begin
            @(posedge clk);
            #0.5;
            if (retired) pulses++;
            check_value("upd_ack", upd_ack, 1);
        end
        upd_req = 1'b0;
        for (n = 1; n <= TIMEOUT; n++) begin
            @(posedge clk);
            #0.5;
            if (retired) pulses++;
            if (!upd_ack) break;
        end
        if (n > TIMEOUT) stop_run("upd_ack stayed high after upd_req dropped");
        check_value("upd_ack_release", n, 1);
    endtask

    task automatic lookup_and_check(input logic [bp_pkg::ADDR_W-1:0] pc,
                                    input logic [bp_pkg::ID_W-1:0] id, output pred_t got);
        pred_t exp;
        exp = ref_lookup(pc, id);
        do_lookup(pc, id, got);
        check_value("pred_hit", got.hit, exp.hit);
        check_value("pred_target", got.target, exp.target);
        check_value("pred_taken", got.taken, exp.taken);
        check_value("pred_is_branch", got.is_branch, exp.is_branch);
        check_value("pred_is_call", got.is_call, exp.is_call);
        check_value("pred_is_return", got.is_return, exp.is_return);
    endtask

    task automatic update_and_check(input logic [bp_pkg::ID_W-1:0] id,
                                    input logic [bp_pkg::ADDR_W-1:0] pc,
                                    input logic [bp_pkg::ADDR_W-1:0] target,
                                    input logic taken, input logic [2:0] kind, input int hold);
        logic exp_retired;
        int   pulses;
        ref_update(id, pc, target, taken, kind, exp_retired);
        do_update(id, pc, target, taken, kind, hold, pulses);
        check_value("retired", pulses, exp_retired);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        pred_t                     res;
        logic [bp_pkg::ADDR_W-1:0] pc;
        logic [bp_pkg::ADDR_W-1:0] target;
        logic [bp_pkg::ID_W-1:0]   id;
        logic [2:0]                kind;
        logic                      taken;
        int                        hold;
        logic [8:0]                dirs;

        seed          = 32'hb8;
        clk           = 1'b0;
        rst_n         = 1'b0;
        // Requests held high through reset must be ignored
        lookup_valid  = 1'b1;
        lookup_pc     = '0;
        lookup_id     = '0;
        upd_req       = 1'b1;
        upd_id        = '0;
        upd_pc        = '0;
        upd_target    = '0;
        upd_taken     = 1'b0;
        upd_is_branch = 1'b1;
        upd_is_call   = 1'b0;
        upd_is_return = 1'b0;
        ref_victim    = 0;
        for (int w = 0; w < bp_pkg::WAYS; w++) begin
            for (int s = 0; s < bp_pkg::SETS; s++) begin
                ref_valid[w][s] = 1'b0;
            end
        end

        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #0.5;
            check_value("upd_ack", upd_ack, 0);
            check_value("retired", retired, 0);
            check_value("pred_valid", pred_valid, 0);
            check_value("pred_hit", pred_hit, 0);
        end
        rst_n         = 1'b1;
        lookup_valid  = 1'b0;
        upd_req       = 1'b0;
        upd_is_branch = 1'b0;

        // Empty table misses everywhere
        for (int i = 0; i < 4; i++) begin
            pc = $random(seed) & 32'hffff_fffc;
            lookup_and_check(pc, i, res);
            check_value("pred_hit", res.hit, 0);
        end

        // Miss then allocate
        lookup_and_check(32'h0000_8124, 1, res);
        update_and_check(1, 32'h0000_8124, 32'h0000_9000, 1'b1, 3'b100, 0);
        lookup_and_check(32'h0000_8124, 2, res);
        check_value("pred_hit", res.hit, 1);
        check_value("pred_target", res.target, 32'h0000_9000);
        check_value("pred_taken", res.taken, 1);

        // Counter walk ending in a call that gives no retired pulse
        lookup_and_check(32'h0000_a3c8, 3, res);
        update_and_check(3, 32'h0000_a3c8, 32'h0000_b000, 1'b0, 3'b100, 0);
        dirs = 9'b1_0000_1111;
        for (int i = 0; i < 9; i++) begin
            lookup_and_check(32'h0000_a3c8, 3, res);
            kind = (i == 8) ? 3'b010 : 3'b100;
            update_and_check(3, 32'h0000_a3c8, 32'h0000_b000, dirs[i], kind, 0);
        end

        // Target kept until the direction flips
        lookup_and_check(32'h0001_0450, 5, res);
        update_and_check(5, 32'h0001_0450, 32'h0000_2000, 1'b1, 3'b100, 0);
        lookup_and_check(32'h0001_0450, 5, res);
        update_and_check(5, 32'h0001_0450, 32'h0000_3000, 1'b1, 3'b100, 0);
        lookup_and_check(32'h0001_0450, 5, res);
        check_value("pred_target", res.target, 32'h0000_2000);
        update_and_check(5, 32'h0001_0450, 32'h0000_3000, 1'b0, 3'b100, 0);
        lookup_and_check(32'h0001_0450, 5, res);
        check_value("pred_target", res.target, 32'h0000_2000);
        update_and_check(5, 32'h0001_0450, 32'h0000_4000, 1'b0, 3'b100, 0);
        lookup_and_check(32'h0001_0450, 6, res);
        check_value("pred_target", res.target, 32'h0000_4000);
        check_value("pred_taken", res.taken, 0);

        // Round-robin eviction of the oldest of three tags in set 0
        for (int k = 1; k <= 3; k++) begin
            pc = k << 12;
            lookup_and_check(pc, 4, res);
            check_value("pred_hit", res.hit, 0);
            update_and_check(4, pc, k << 8, 1'b1, 3'b010, 0);
        end
        lookup_and_check(32'h0000_1000, 4, res);
        check_value("pred_hit", res.hit, 0);
        lookup_and_check(32'h0000_2000, 4, res);
        check_value("pred_hit", res.hit, 1);
        lookup_and_check(32'h0000_3000, 4, res);
        check_value("pred_hit", res.hit, 1);

        // Random pairs with four tags competing for each of two sets
        for (int i = 0; i < POOL; i++) begin
            pool[i] = 32'h0004_0000 | ((i % 4) << 12) | ((i / 4) << 2);
        end
        for (int i = 0; i < 300; i++) begin
            pc     = pool[$unsigned($random(seed)) % POOL];
            id     = $random(seed);
            target = $random(seed) & 32'hffff_fffc;
            taken  = $random(seed);
            kind   = $random(seed);
            hold   = $unsigned($random(seed)) % 4;
            lookup_and_check(pc, id, res);
            update_and_check(id, pc, target, taken, kind, hold);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

/* all.f */
source/bp_pkg.sv
source/bp_index_hash.sv
source/bp_way_bank.sv
source/bp_hit_select.sv
source/bp_update_ctrl.sv
source/branch_predictor.sv
verif/tb_branch_predictor.sv

/* Bender.yml */
package:
  name: branch_predictor

dependencies: {}

sources:
  # RTL in compile order, package first
  - files:
      - source/bp_pkg.sv
      - source/bp_index_hash.sv
      - source/bp_way_bank.sv
      - source/bp_hit_select.sv
      - source/bp_update_ctrl.sv
      - source/branch_predictor.sv

  # Testbench, top module tb_branch_predictor
  - target: test
    files:
      - verif/tb_branch_predictor.sv
